// ==== branch_cfg_if.sv ====
/*
 * Branch configuration interface
 * Carries one single-cycle table write to every branch slot
 */
`timescale 1ns/1ps

interface branch_cfg_if;

    logic                   wren;
    branch_pkg::slot_t      slot;
    branch_pkg::cfg_field_e field;
    branch_pkg::thread_t    thread;
    branch_pkg::cfg_data_t  data;

    // Driven by the top level
    modport source (
        output wren,
        output slot,
        output field,
        output thread,
        output data
    );

    // Seen by each slot and its table
    modport sink (
        input wren,
        input slot,
        input field,
        input thread,
        input data
    );

endinterface

// ==== branch_check.sv ====
/*
 * Branch check
 * One branch slot: origin match, flag test and prediction cancel per thread.
 * Produces zeros on no branch so the top level can OR all slots together
 */
`timescale 1ns/1ps

module branch_check #(
    parameter int SLOT_INDEX = 0
) (
    input  logic                clock,
    input  logic                rst_n,
    branch_cfg_if.sink          cfg,
    input  branch_pkg::thread_t read_thread,
    input  branch_pkg::pc_t     pc,
    input  branch_pkg::flags_t  flags,
    input  logic                io_ready_previous,
    output branch_pkg::pc_t     slot_destination,
    output logic                slot_jump,
    output logic                slot_cancel
);

    branch_pkg::pc_t       table_origin;
    branch_pkg::pc_t       table_destination;
    branch_pkg::flag_sel_t table_flag_sel;
    logic                  table_cond_enable;
    logic                  table_predict_taken;
    logic                  table_predict_enable;

    branch_table #(
        .SLOT_INDEX     (SLOT_INDEX)
    ) branch_table_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .read_thread    (read_thread),
        .origin         (table_origin),
        .destination    (table_destination),
        .flag_sel       (table_flag_sel),
        .cond_enable    (table_cond_enable),
        .predict_taken  (table_predict_taken),
        .predict_enable (table_predict_enable)
    );

    // ----------------------------------------
    // PC alignment with the table read
    // ----------------------------------------
    branch_pkg::pc_t pc_pipe [branch_pkg::PC_SYNC_DEPTH];
    branch_pkg::pc_t pc_synced;

    always_ff @(posedge clock) begin
        pc_pipe[0] <= pc;
        for (int i = 1; i < branch_pkg::PC_SYNC_DEPTH; i++) begin
            pc_pipe[i] <= pc_pipe[i-1];
        end
    end

    assign pc_synced = pc_pipe[branch_pkg::PC_SYNC_DEPTH-1];

    // ----------------------------------------
    // Stage 1: origin compare
    // ----------------------------------------
    // Flags and io_ready arrive one cycle after the PC, so they are captured here
    logic                  hit_s1;
    logic                  io_ready_s1;
    logic                  predict_enable_s1;
    branch_pkg::flags_t    flags_s1;
    branch_pkg::flag_sel_t flag_sel_s1;
    branch_pkg::pc_t       destination_s1;
    logic                  predict_taken_s1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hit_s1            <= 1'b0;
            io_ready_s1       <= 1'b0;
            predict_enable_s1 <= 1'b0;
        end else begin
            hit_s1            <= table_cond_enable && (pc_synced == table_origin);
            io_ready_s1       <= io_ready_previous;
            predict_enable_s1 <= table_predict_enable;
        end
    end

    always_ff @(posedge clock) begin
        flags_s1         <= flags;
        flag_sel_s1      <= table_flag_sel;
        destination_s1   <= table_destination;
        predict_taken_s1 <= table_predict_taken;
    end

    // ----------------------------------------
    // Stage 2: flag select and masking
    // ----------------------------------------
    // One bit per thread in flight, so the tap is this thread's last decision
    logic [branch_pkg::THREAD_COUNT-1:0] jump_history;
    logic                                flag;
    logic                                jump_next;
    logic                                cancel_next;
    branch_pkg::pc_t                     destination_next;

    // A re-issued instruction reuses its earlier decision, since its own
    // previous result was annulled and says nothing about the branch
    assign flag = io_ready_s1 ? flags_s1[flag_sel_s1]
                              : jump_history[branch_pkg::THREAD_COUNT-1];

    assign jump_next        = hit_s1 & flag;
    assign destination_next = jump_next ? destination_s1 : '0;
    assign cancel_next      = hit_s1 & predict_enable_s1 & (predict_taken_s1 != flag);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            jump_history <= '0;
        end else begin
            jump_history <= {jump_history[branch_pkg::THREAD_COUNT-2:0], jump_next};
        end
    end

    logic            jump_s2;
    logic            cancel_s2;
    branch_pkg::pc_t destination_s2;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            jump_s2        <= 1'b0;
            cancel_s2      <= 1'b0;
            destination_s2 <= '0;
        end else begin
            jump_s2        <= jump_next;
            cancel_s2      <= cancel_next;
            destination_s2 <= destination_next;
        end
    end

    // ----------------------------------------
    // Stage 3: output registers
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            slot_jump        <= 1'b0;
            slot_cancel      <= 1'b0;
            slot_destination <= '0;
        end else begin
            slot_jump        <= jump_s2;
            slot_cancel      <= cancel_s2;
            slot_destination <= destination_s2;
        end
    end

endmodule

// ==== branch_pkg.sv ====
/*
 * Branch unit shared definitions
 * Widths, thread and slot counts, pipeline depths and config encodings
 */
package branch_pkg;

    // ----------------------------------------
    // Widths and counts
    // ----------------------------------------
    localparam int PC_WIDTH        = 10;
    localparam int FLAGS_WIDTH     = 8;
    localparam int FLAG_SEL_WIDTH  = 3;
    localparam int THREAD_WIDTH    = 3;
    localparam int SLOT_WIDTH      = 1;
    localparam int CFG_DATA_WIDTH  = 10;
    localparam int CFG_FIELD_WIDTH = 2;

    localparam int THREAD_COUNT = 8;
    localparam int SLOT_COUNT   = 2;

    // Cycles from the pc input to the origin comparison
    localparam int PC_SYNC_DEPTH  = 1;
    // Cycles from an instruction's inputs to its outputs
    localparam int RESULT_LATENCY = 3;

    // ----------------------------------------
    // Payload layout of configuration writes
    // ----------------------------------------
    // A condition write carries the flag index in bits 2..0 and the enable in bit 3
    localparam int COND_ENABLE_BIT = 3;
    // A prediction write carries predicted-taken in bit 0 and the enable in bit 1
    localparam int PRED_TAKEN_BIT  = 0;
    localparam int PRED_ENABLE_BIT = 1;

    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [FLAGS_WIDTH-1:0]    flags_t;
    typedef logic [FLAG_SEL_WIDTH-1:0] flag_sel_t;
    typedef logic [THREAD_WIDTH-1:0]   thread_t;
    typedef logic [SLOT_WIDTH-1:0]     slot_t;
    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;

    // Table field targeted by a configuration write
    typedef enum logic [CFG_FIELD_WIDTH-1:0] {
        cfg_origin      = 2'd0,
        cfg_destination = 2'd1,
        cfg_condition   = 2'd2,
        cfg_prediction  = 2'd3
    } cfg_field_e;

endpackage

// ==== branch_table.sv ====
/*
 * Branch table
 * Per-thread origin, destination, condition and prediction of one slot
 */
`timescale 1ns/1ps

module branch_table #(
    parameter int SLOT_INDEX = 0
) (
    input  logic                  clock,
    input  logic                  rst_n,
    branch_cfg_if.sink            cfg,
    input  branch_pkg::thread_t   read_thread,
    output branch_pkg::pc_t       origin,
    output branch_pkg::pc_t       destination,
    output branch_pkg::flag_sel_t flag_sel,
    output logic                  cond_enable,
    output logic                  predict_taken,
    output logic                  predict_enable
);

    branch_pkg::pc_t       origin_mem      [branch_pkg::THREAD_COUNT];
    branch_pkg::pc_t       destination_mem [branch_pkg::THREAD_COUNT];
    branch_pkg::flag_sel_t flag_sel_mem    [branch_pkg::THREAD_COUNT];
    logic [branch_pkg::THREAD_COUNT-1:0] predict_taken_mem;
    logic [branch_pkg::THREAD_COUNT-1:0] cond_enable_mem;
    logic [branch_pkg::THREAD_COUNT-1:0] predict_enable_mem;
    logic                                slot_wren;

    // Only writes addressed to this slot land here
    assign slot_wren = cfg.wren && (cfg.slot == branch_pkg::slot_t'(SLOT_INDEX));

    // ----------------------------------------
    // Writes
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (slot_wren) begin
            case (cfg.field)
                branch_pkg::cfg_origin:
                    origin_mem[cfg.thread] <= cfg.data;
                branch_pkg::cfg_destination:
                    destination_mem[cfg.thread] <= cfg.data;
                branch_pkg::cfg_condition:
                    flag_sel_mem[cfg.thread] <= cfg.data[branch_pkg::FLAG_SEL_WIDTH-1:0];
                branch_pkg::cfg_prediction:
                    predict_taken_mem[cfg.thread] <= cfg.data[branch_pkg::PRED_TAKEN_BIT];
            endcase
        end
    end

    // Enables start cleared, so a freshly reset slot never matches
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cond_enable_mem    <= '0;
            predict_enable_mem <= '0;
        end else if (slot_wren) begin
            if (cfg.field == branch_pkg::cfg_condition) begin
                cond_enable_mem[cfg.thread] <= cfg.data[branch_pkg::COND_ENABLE_BIT];
            end
            if (cfg.field == branch_pkg::cfg_prediction) begin
                predict_enable_mem[cfg.thread] <= cfg.data[branch_pkg::PRED_ENABLE_BIT];
            end
        end
    end

    // ----------------------------------------
    // Registered read
    // ----------------------------------------
    always_ff @(posedge clock) begin
        origin        <= origin_mem[read_thread];
        destination   <= destination_mem[read_thread];
        flag_sel      <= flag_sel_mem[read_thread];
        predict_taken <= predict_taken_mem[read_thread];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cond_enable    <= 1'b0;
            predict_enable <= 1'b0;
        end else begin
            cond_enable    <= cond_enable_mem[read_thread];
            predict_enable <= predict_enable_mem[read_thread];
        end
    end

endmodule

// ==== branch_testdata.txt ====
# One line per clock, thread = line index mod 8. W: slot field(0 org 1 dst 2 cond 3 pred) thread data
# I: pc flags io_ready_previous, expected destination jump cancel (all hex)
# Rotation 0: reset state, then slot 0 thread 2 and slot 1 thread 5 are configured
I 2A0 FF 1 000 0 0
W 0 0 2 2A0
W 0 1 2 155
W 0 2 2 00D
W 0 3 2 003
W 1 0 5 3C4
W 1 1 5 0F0
W 1 2 5 009
# Rotation 1: hits on the configured threads only
I 2A0 20 1 000 0 0
I 2A0 20 1 000 0 0
I 2A0 20 1 155 1 0
I 2A0 20 1 000 0 0
I 3C4 02 1 000 0 0
I 3C4 02 1 0F0 1 0
I 3C4 02 1 000 0 0
I 155 FF 1 000 0 0
# Rotation 2: flag clear gives cancel on slot 0, none on slot 1
I 000 00 1 000 0 0
I 3C4 FF 1 000 0 0
I 2A0 DF 1 000 0 1
I 2A1 FF 1 000 0 0
I 000 00 1 000 0 0
I 3C4 FD 1 000 0 0
I 2A0 FF 1 000 0 0
I 000 00 1 000 0 0
# Rotation 3: re-issue on thread 2 repeats not-taken
I 000 00 1 000 0 0
I 000 00 1 000 0 0
I 2A0 FF 0 000 0 1
I 000 00 1 000 0 0
I 000 00 1 000 0 0
I 3C4 02 1 0F0 1 0
I 000 00 1 000 0 0
I 000 00 1 000 0 0
# Rotation 4: re-issue on thread 5 repeats taken, thread 2 moves to flag 2
I 000 00 1 000 0 0
I 000 00 1 000 0 0
I 2A0 20 1 155 1 0
W 0 2 2 00A
I 000 00 1 000 0 0
I 3C4 00 0 0F0 1 0
I 000 00 1 000 0 0
I 000 00 1 000 0 0
# Rotation 5: flag 2 now decides thread 2
I 000 00 1 000 0 0
I 000 00 1 000 0 0
I 2A0 04 1 155 1 0

// ==== branch_thread_counter.sv ====
/*
 * Branch thread counter
 * Names the thread whose PC enters the branch pipeline this cycle
 */
`timescale 1ns/1ps

module branch_thread_counter (
    input  logic                clock,
    input  logic                rst_n,
    output branch_pkg::thread_t read_thread
);

    localparam branch_pkg::thread_t LAST_THREAD =
        branch_pkg::thread_t'(branch_pkg::THREAD_COUNT - 1);

    // Strict rotation, one thread per clock, thread 0 first after reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_thread <= '0;
        end else if (read_thread == LAST_THREAD) begin
            read_thread <= '0;
        end else begin
            read_thread <= read_thread + 1'b1;
        end
    end

endmodule

// ==== branch_unit.sv ====
/*
 * Branch resolution unit
 * Thread counter plus one branch check per slot, outputs OR-reduced
 */
`timescale 1ns/1ps

module branch_unit (
    input  logic                   clock,
    input  logic                   rst_n,
    input  branch_pkg::pc_t        pc,
    input  branch_pkg::flags_t     flags,
    input  logic                   io_ready_previous,
    input  logic                   cfg_wren,
    input  branch_pkg::slot_t      cfg_slot,
    input  branch_pkg::cfg_field_e cfg_field,
    input  branch_pkg::thread_t    cfg_thread,
    input  branch_pkg::cfg_data_t  cfg_data,
    output branch_pkg::pc_t        branch_destination,
    output logic                   jump,
    output logic                   cancel
);

    branch_pkg::thread_t                read_thread;
    branch_pkg::pc_t                    slot_destination [branch_pkg::SLOT_COUNT];
    logic [branch_pkg::SLOT_COUNT-1:0]  slot_jump;
    logic [branch_pkg::SLOT_COUNT-1:0]  slot_cancel;

    branch_cfg_if cfg ();

    assign cfg.wren   = cfg_wren;
    assign cfg.slot   = cfg_slot;
    assign cfg.field  = cfg_field;
    assign cfg.thread = cfg_thread;
    assign cfg.data   = cfg_data;

    branch_thread_counter branch_thread_counter_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .read_thread (read_thread)
    );

    // ----------------------------------------
    // Branch slots
    // ----------------------------------------
    for (genvar i = 0; i < branch_pkg::SLOT_COUNT; i++) begin : gen_slot
        branch_check #(
            .SLOT_INDEX        (i)
        ) branch_check_inst (
            .clock             (clock),
            .rst_n             (rst_n),
            .cfg               (cfg),
            .read_thread       (read_thread),
            .pc                (pc),
            .flags             (flags),
            .io_ready_previous (io_ready_previous),
            .slot_destination  (slot_destination[i]),
            .slot_jump         (slot_jump[i]),
            .slot_cancel       (slot_cancel[i])
        );
    end

    // Slots that do not branch output zero, so OR gives the winning slot
    always_comb begin
        branch_destination = '0;
        for (int i = 0; i < branch_pkg::SLOT_COUNT; i++) begin
            branch_destination = branch_destination | slot_destination[i];
        end
    end

    assign jump   = |slot_jump;
    assign cancel = |slot_cancel;

endmodule

// ==== build.f ====
branch_pkg.sv
branch_cfg_if.sv
branch_thread_counter.sv
branch_table.sv
branch_check.sv
branch_unit.sv
tb_branch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the branch unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_branch_unit -o sim_branch_unit

./obj_dir/sim_branch_unit | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== tb_branch_unit.sv ====
/*
 * Branch unit testbench
 * Replays table writes and instructions from the test data file, one line
 * per clock, and checks each instruction's outputs after the result latency
 */
`timescale 1ns/1ps

module tb_branch_unit;

    localparam int    CLOCK_PERIOD  = 40;
    localparam int    RESET_CYCLES  = 8;
    localparam int    MAX_LINES     = 256;
    localparam string DATA_FILE     = "branch_testdata.txt";
    localparam int    CHECK_DELAY   = branch_pkg::RESULT_LATENCY + 1;
    // Idle PCs stay below every origin used in the test data
    localparam int    IDLE_PC_RANGE = 512;

    logic                   clock;
    logic                   rst_n;
    branch_pkg::pc_t        pc;
    branch_pkg::flags_t     flags;
    logic                   io_ready_previous;
    logic                   cfg_wren;
    branch_pkg::slot_t      cfg_slot;
    branch_pkg::cfg_field_e cfg_field;
    branch_pkg::thread_t    cfg_thread;
    branch_pkg::cfg_data_t  cfg_data;
    branch_pkg::pc_t        branch_destination;
    logic                   jump;
    logic                   cancel;

    // W lines hold slot, field, thread and data
    // I lines hold pc, flags, io_ready and the expected destination, jump and cancel
    bit is_write  [MAX_LINES];
    int file_line [MAX_LINES];
    int fields    [MAX_LINES][6];
    int line_count;
    int checks_done;
    int checks_expected;
    bit load_done;

    branch_unit branch_unit_inst (
        .clock              (clock),
        .rst_n              (rst_n),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .cfg_wren           (cfg_wren),
        .cfg_slot           (cfg_slot),
        .cfg_field          (cfg_field),
        .cfg_thread         (cfg_thread),
        .cfg_data           (cfg_data),
        .branch_destination (branch_destination),
        .jump               (jump),
        .cancel             (cancel)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end else begin
            checks_done++;
        end
    endtask

    task automatic load_test_data();
        int    fd;
        int    code;
        int    wanted;
        int    number;
        string text;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            stop_run({"Cannot open the test data file ", DATA_FILE});
        end
        number = 0;
        while ($fgets(text, fd) != 0) begin
            number++;
            if (text.len() < 2 || text.substr(0, 0) == "#") begin
                continue;
            end
            if (line_count == MAX_LINES) begin
                stop_run("The test data file has more lines than the testbench can hold");
            end
            if (text.substr(0, 0) == "W") begin
                is_write[line_count] = 1'b1;
                wanted = 4;
                code = $sscanf(text, "W %h %h %h %h", fields[line_count][0],
                               fields[line_count][1], fields[line_count][2],
                               fields[line_count][3]);
            end else if (text.substr(0, 0) == "I") begin
                is_write[line_count] = 1'b0;
                wanted = 6;
                checks_expected += 3;
                code = $sscanf(text, "I %h %h %h %h %h %h", fields[line_count][0],
                               fields[line_count][1], fields[line_count][2],
                               fields[line_count][3], fields[line_count][4],
                               fields[line_count][5]);
            end else begin
                stop_run($sformatf("Unknown line type on test data line %0d", number));
            end
            if (code != wanted) begin
                stop_run($sformatf("Test data line %0d is malformed", number));
            end
            file_line[line_count] = number;
            line_count++;
        end
        $fclose(fd);
    endtask

    // Line n's pc and write go out now and the flags of line n-1 follow one clock late
    task automatic drive_inputs(input int n);
        cfg_wren = 1'b0;
        if (n < line_count && !is_write[n]) begin
            pc = branch_pkg::pc_t'(fields[n][0]);
        end else begin
            pc = branch_pkg::pc_t'($urandom % IDLE_PC_RANGE);
        end
        if (n < line_count && is_write[n]) begin
            cfg_wren   = 1'b1;
            cfg_slot   = branch_pkg::slot_t'(fields[n][0]);
            cfg_field  = branch_pkg::cfg_field_e'(fields[n][1]);
            cfg_thread = branch_pkg::thread_t'(fields[n][2]);
            cfg_data   = branch_pkg::cfg_data_t'(fields[n][3]);
        end
        if (n >= 1 && n - 1 < line_count && !is_write[n-1]) begin
            flags             = branch_pkg::flags_t'(fields[n-1][1]);
            io_ready_previous = (fields[n-1][2] != 0);
        end else begin
            flags             = branch_pkg::flags_t'($urandom);
            io_ready_previous = 1'b1;
        end
    endtask

    task automatic check_outputs(input int k);
        string tag;
        tag = $sformatf("line %0d", file_line[k]);
        check_value({tag, " branch_destination"}, fields[k][3], branch_destination);
        check_value({tag, " jump"}, fields[k][4], jump);
        check_value({tag, " cancel"}, fields[k][5], cancel);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        void'($urandom(32'h2afc9c1d));
        rst_n             = 1'b0;
        pc                = '0;
        flags             = '0;
        io_ready_previous = 1'b1;
        cfg_wren          = 1'b0;
        cfg_slot          = '0;
        cfg_field         = branch_pkg::cfg_origin;
        cfg_thread        = '0;
        cfg_data          = '0;
        load_test_data();
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        for (int n = 0; n < line_count + CHECK_DELAY; n++) begin
            @(negedge clock);
            rst_n = 1'b1;
            if (n >= CHECK_DELAY && !is_write[n-CHECK_DELAY]) begin
                check_outputs(n - CHECK_DELAY);
            end
            drive_inputs(n);
        end
        if (checks_expected > 0 && checks_done == checks_expected) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run($sformatf("Only %0d of %0d output checks ran",
                               checks_done, checks_expected));
        end
    end

    initial begin
        int limit_ns;
        wait (load_done);
        limit_ns = (line_count + 20) * 8 * CLOCK_PERIOD;
        #(limit_ns);
        stop_run("Timeout: the test sequence did not finish in time");
    end

endmodule
